//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_uart_top
RTL_TOP    = uart_top
FILELIST   = uart_periph.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/byte_fifo.sv
`timescale 1ns/10ps

module byte_fifo #(
    parameter int DEPTH = 32
) (
    input  logic   clk_i,
    input  logic   rstn_i,
    fifo_if.fifo   f
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [7:0]    mem_q [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;
    logic          push_w;
    logic          pop_w;

    // Blocked pushes and pops are dropped here
    assign push_w = f.wr_en && !f.full;
    assign pop_w  = f.rd_en && !f.empty;

    assign f.full    = (count_q == CW'(DEPTH));
    assign f.empty   = (count_q == '0);
    // Head of queue is visible without a read strobe
    assign f.rd_data = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push_w) begin
            mem_q[wr_ptr_q] <= f.wr_data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_w) begin
                wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_w) begin
                rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push_w && !pop_w) begin
                count_q <= count_q + 1'b1;
            end else if (pop_w && !push_w) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

//--- hdl/fifo_if.sv
`timescale 1ns/10ps

interface fifo_if;

    logic [7:0] wr_data;
    logic       wr_en;
    logic [7:0] rd_data;
    logic       rd_en;
    logic       full;
    logic       empty;

    modport fifo (
        input  wr_data, wr_en, rd_en,
        output rd_data, full, empty
    );

    // Both sides see both flags, the controller builds status from them
    modport producer (output wr_data, wr_en, input full, empty);

    modport consumer (output rd_en, input rd_data, full, empty);

endinterface

//--- hdl/uart_pkg.sv
package uart_pkg;

    // ===================================================================
    // Bus address window
    // ===================================================================

    localparam logic [31:0] UART_BASE_ADDR = 32'h1000_0000;
    // Low address bits select one of the registers
    localparam logic [31:0] UART_ADDR_MASK = 32'h0000_000F;

    // Register offsets inside the window
    localparam logic [3:0] REG_CTRL   = 4'h0;
    localparam logic [3:0] REG_STATUS = 4'h4;
    localparam logic [3:0] REG_RDATA  = 4'h8;
    localparam logic [3:0] REG_WDATA  = 4'hC;

    // ===================================================================
    // Bus opcodes
    // ===================================================================

    // Request channel
    localparam logic [2:0] OP_PUT_FULL = 3'd0;
    localparam logic [2:0] OP_PUT_PART = 3'd1;
    localparam logic [2:0] OP_GET      = 3'd4;

    // Response channel
    localparam logic [2:0] OP_ACK      = 3'd0;
    localparam logic [2:0] OP_ACK_DATA = 3'd1;

    // Byte FIFO depth unless the top level overrides it
    localparam int FIFO_DEPTH_DEF = 32;

    // ===================================================================
    // Control register
    // ===================================================================

    // Field view used by the serial engines
    typedef struct packed {
        logic [15:0] baud_div;
        logic [13:0] rsvd;
        logic        rx_en;
        logic        tx_en;
    } uart_ctrl_s;

    // Bus side stores and returns the raw word
    typedef union packed {
        logic [31:0] raw;
        uart_ctrl_s  fields;
    } uart_ctrl_u;

endpackage

//--- hdl/uart_regs.sv
`timescale 1ns/10ps

module uart_regs (
    input  logic                clk_i,
    input  logic                rstn_i,

    input  logic                req_valid_i,
    input  logic [31:0]         req_addr_i,
    input  logic [31:0]         req_data_i,
    input  logic [2:0]          req_op_i,
    output logic                req_ready_o,

    output logic                rsp_valid_o,
    output logic [31:0]         rsp_data_o,
    output logic [2:0]          rsp_op_o,
    input  logic                rsp_ready_i,

    output uart_pkg::uart_ctrl_u ctrl_o,
    fifo_if.producer            txq,
    fifo_if.consumer            rxq
);

    import uart_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_DATA,
        ST_WAIT_SPACE
    } state_t;

    state_t      state_q, state_d;
    uart_ctrl_u  ctrl_q, ctrl_d;
    logic        rsp_valid_q, rsp_valid_d;
    logic [31:0] rsp_data_q, rsp_data_d;
    logic [2:0]  rsp_op_q, rsp_op_d;
    logic [7:0]  hold_q, hold_d;

    logic        in_win_w;
    logic        accept_w;
    logic        is_write_w;
    logic        is_read_w;
    logic [3:0]  reg_off_w;
    logic [3:0]  status_w;

    // ===================================================================
    // Request decode
    // ===================================================================

    assign in_win_w   = ((req_addr_i & ~UART_ADDR_MASK) == UART_BASE_ADDR);
    assign reg_off_w  = req_addr_i[3:0];
    assign is_write_w = (req_op_i == OP_PUT_FULL) || (req_op_i == OP_PUT_PART);
    assign is_read_w  = (req_op_i == OP_GET);

    // Stalls in either wait state and behind an unaccepted response
    assign req_ready_o = (state_q == ST_IDLE) && !rsp_valid_q;
    // Out-of-window requests are taken and dropped
    assign accept_w    = req_valid_i && req_ready_o && in_win_w;

    assign status_w = {rxq.empty, rxq.full, txq.empty, txq.full};

    // ===================================================================
    // Next state and FIFO control
    // ===================================================================

    always_comb begin
        state_d     = state_q;
        ctrl_d      = ctrl_q;
        rsp_valid_d = rsp_valid_q;
        rsp_data_d  = rsp_data_q;
        rsp_op_d    = rsp_op_q;
        hold_d      = hold_q;
        txq.wr_en   = 1'b0;
        txq.wr_data = (state_q == ST_WAIT_SPACE) ? hold_q : req_data_i[7:0];
        rxq.rd_en   = 1'b0;

        if (rsp_valid_q && rsp_ready_i) begin
            rsp_valid_d = 1'b0;
        end

        case (state_q)
            ST_IDLE: begin
                if (accept_w) begin
                    rsp_valid_d = 1'b1;
                    rsp_op_d    = is_read_w ? OP_ACK_DATA : OP_ACK;
                    rsp_data_d  = '0;
                    case (reg_off_w)
                        REG_CTRL: begin
                            if (is_read_w) rsp_data_d = ctrl_q.raw;
                            else if (is_write_w) ctrl_d.raw = req_data_i;
                        end
                        REG_STATUS: begin
                            if (is_read_w) rsp_data_d = {28'd0, status_w};
                        end
                        REG_RDATA: begin
                            if (is_read_w && rxq.empty) begin
                                // Answer later, once a byte arrives
                                rsp_valid_d = 1'b0;
                                state_d     = ST_WAIT_DATA;
                            end else if (is_read_w) begin
                                rsp_data_d = {24'd0, rxq.rd_data};
                                rxq.rd_en  = 1'b1;
                            end
                        end
                        REG_WDATA: begin
                            if (is_write_w && txq.full) begin
                                hold_d  = req_data_i[7:0];
                                state_d = ST_WAIT_SPACE;
                            end else if (is_write_w) begin
                                txq.wr_en = 1'b1;
                            end
                        end
                        default: ;
                    endcase
                end
            end
            ST_WAIT_DATA: begin
                if (!rxq.empty) begin
                    rsp_valid_d = 1'b1;
                    rsp_op_d    = OP_ACK_DATA;
                    rsp_data_d  = {24'd0, rxq.rd_data};
                    rxq.rd_en   = 1'b1;
                    state_d     = ST_IDLE;
                end
            end
            default: begin
                // ACK already sent, push the held byte when room frees
                if (!txq.full) begin
                    txq.wr_en = 1'b1;
                    state_d   = ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q     <= ST_IDLE;
            ctrl_q.raw  <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            ctrl_q      <= ctrl_d;
            rsp_valid_q <= rsp_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        rsp_data_q <= rsp_data_d;
        rsp_op_q   <= rsp_op_d;
        hold_q     <= hold_d;
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_data_o  = rsp_data_q;
    assign rsp_op_o    = rsp_op_q;
    assign ctrl_o      = ctrl_q;

endmodule

//--- hdl/uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        rx_en_i,
    input  logic [15:0] baud_div_i,
    input  logic        rx_i,
    fifo_if.producer    q
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t   state_q;
    logic        rx_meta_q;
    logic        rx_sync_q;
    logic        rx_prev_q;
    logic [15:0] baud_cnt_q;
    logic [2:0]  bit_idx_q;
    logic [7:0]  shift_q;
    logic        push_q;
    logic        fall_w;
    logic        half_done_w;
    logic        bit_done_w;

    assign fall_w      = rx_prev_q && !rx_sync_q;
    assign half_done_w = (baud_cnt_q == (baud_div_i >> 1) - 16'd1);
    assign bit_done_w  = (baud_cnt_q == baud_div_i - 16'd1);

    assign q.wr_en   = push_q;
    assign q.wr_data = shift_q;

    // Two-flop synchronizer plus one stage for edge detection
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            rx_prev_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
            rx_prev_q <= rx_sync_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == RX_DATA && bit_done_w) begin
            shift_q <= {rx_sync_q, shift_q[7:1]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q    <= RX_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            push_q     <= 1'b0;
        end else begin
            push_q     <= 1'b0;
            baud_cnt_q <= baud_cnt_q + 16'd1;
            case (state_q)
                RX_IDLE: begin
                    baud_cnt_q <= '0;
                    bit_idx_q  <= '0;
                    if (fall_w) state_q <= RX_START;
                end
                RX_START: begin
                    // Middle of start bit, a glitch returns to idle
                    if (half_done_w) begin
                        baud_cnt_q <= '0;
                        state_q    <= rx_sync_q ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_done_w) begin
                        baud_cnt_q <= '0;
                        bit_idx_q  <= bit_idx_q + 3'd1;
                        if (bit_idx_q == 3'd7) state_q <= RX_STOP;
                    end
                end
                default: begin
                    if (bit_done_w) begin
                        push_q  <= rx_sync_q && rx_en_i && !q.full;
                        state_q <= RX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- hdl/uart_top.sv
`timescale 1ns/10ps

module uart_top #(
    parameter int FIFO_DEPTH = uart_pkg::FIFO_DEPTH_DEF
) (
    input  logic        clk_i,
    input  logic        rstn_i,

    input  logic        req_valid_i,
    input  logic [31:0] req_addr_i,
    input  logic [31:0] req_data_i,
    input  logic [2:0]  req_op_i,
    output logic        req_ready_o,

    output logic        rsp_valid_o,
    output logic [31:0] rsp_data_o,
    output logic [2:0]  rsp_op_o,
    input  logic        rsp_ready_i,

    input  logic        rx_i,
    output logic        tx_o
);

    import uart_pkg::*;

    uart_ctrl_u ctrl;

    fifo_if txq_if ();
    fifo_if rxq_if ();

    uart_regs regs0 (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid_i (req_valid_i),
        .req_addr_i  (req_addr_i),
        .req_data_i  (req_data_i),
        .req_op_i    (req_op_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_data_o  (rsp_data_o),
        .rsp_op_o    (rsp_op_o),
        .rsp_ready_i (rsp_ready_i),
        .ctrl_o      (ctrl),
        .txq         (txq_if.producer),
        .rxq         (rxq_if.consumer)
    );

    byte_fifo #(.DEPTH(FIFO_DEPTH)) tx_fifo0 (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .f      (txq_if.fifo)
    );

    byte_fifo #(.DEPTH(FIFO_DEPTH)) rx_fifo0 (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .f      (rxq_if.fifo)
    );

    // Serial engines read the field view of the control word
    uart_tx tx0 (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .tx_en_i    (ctrl.fields.tx_en),
        .baud_div_i (ctrl.fields.baud_div),
        .q          (txq_if.consumer),
        .tx_o       (tx_o)
    );

    uart_rx rx0 (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .rx_en_i    (ctrl.fields.rx_en),
        .baud_div_i (ctrl.fields.baud_div),
        .rx_i       (rx_i),
        .q          (rxq_if.producer)
    );

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        tx_en_i,
    input  logic [15:0] baud_div_i,
    fifo_if.consumer    q,
    output logic        tx_o
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t   state_q;
    logic [15:0] baud_cnt_q;
    logic [2:0]  bit_idx_q;
    logic [7:0]  shift_q;
    logic        pop_q;
    logic        tx_q;
    logic        start_w;
    logic        bit_done_w;

    assign start_w    = (state_q == TX_IDLE) && tx_en_i && !q.empty;
    assign bit_done_w = (baud_cnt_q == baud_div_i - 16'd1);

    // Pop lands one cycle after the head is captured
    assign q.rd_en = pop_q;
    assign tx_o    = tx_q;

    always_ff @(posedge clk_i) begin
        if (start_w) begin
            shift_q <= q.rd_data;
        end else if (state_q == TX_DATA && bit_done_w) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q    <= TX_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            pop_q      <= 1'b0;
            tx_q       <= 1'b1;
        end else begin
            pop_q <= start_w;
            baud_cnt_q <= (state_q == TX_IDLE || bit_done_w) ? '0 : baud_cnt_q + 16'd1;
            case (state_q)
                TX_IDLE: begin
                    tx_q      <= 1'b1;
                    bit_idx_q <= '0;
                    if (start_w) state_q <= TX_START;
                end
                TX_START: begin
                    tx_q <= 1'b0;
                    if (bit_done_w) state_q <= TX_DATA;
                end
                TX_DATA: begin
                    // LSB first
                    tx_q <= shift_q[0];
                    if (bit_done_w) begin
                        bit_idx_q <= bit_idx_q + 3'd1;
                        if (bit_idx_q == 3'd7) state_q <= TX_STOP;
                    end
                end
                default: begin
                    tx_q <= 1'b1;
                    if (bit_done_w) state_q <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

//--- testbench/tb_uart_top.sv
`timescale 1ns/10ps

module tb_uart_top;

    import uart_pkg::*;

    localparam int BAUD_DIV       = 8;
    localparam int FRAME_CYCLES   = 10 * BAUD_DIV;
    // 1 frame in the transmit test, 3 in loopback, 34 in the full-FIFO test
    localparam int NUM_FRAMES     = 38;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES + 2000;

    localparam logic [31:0] CTRL_OFF  = {16'(BAUD_DIV), 16'h0000};
    localparam logic [31:0] CTRL_TX   = CTRL_OFF | 32'h1;
    localparam logic [31:0] CTRL_TXRX = CTRL_OFF | 32'h3;

    logic        clk_i;
    logic        rstn_i;
    logic        req_valid_i;
    logic [31:0] req_addr_i;
    logic [31:0] req_data_i;
    logic [2:0]  req_op_i;
    logic        req_ready_o;
    logic        rsp_valid_o;
    logic [31:0] rsp_data_o;
    logic [2:0]  rsp_op_o;
    logic        rsp_ready_i;
    logic        tx_o;

    int          seed = 79;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic [7:0]  tx_expect[$];
    logic [7:0]  tx_seen[$];

    // Serial loopback
    uart_top #(.FIFO_DEPTH(FIFO_DEPTH_DEF)) dut0 (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid_i (req_valid_i),
        .req_addr_i  (req_addr_i),
        .req_data_i  (req_data_i),
        .req_op_i    (req_op_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_data_o  (rsp_data_o),
        .rsp_op_o    (rsp_op_o),
        .rsp_ready_i (rsp_ready_i),
        .rx_i        (tx_o),
        .tx_o        (tx_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // ===================================================================
    // Checking and bus tasks
    // ===================================================================

    task automatic check_equal(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        end
    endtask

    // Called one step after a rising edge and returns at the same phase
    task automatic bus_access(input logic [2:0] op, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic [2:0] rop, output int lat);
        int          coin;
        logic [31:0] first_data;
        req_valid_i = 1'b1;
        req_op_i    = op;
        req_addr_i  = addr;
        req_data_i  = wdata;
        while (!req_ready_o) begin
            @(posedge clk_i);
            #1;
        end
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b0;
        lat = 1;
        while (!rsp_valid_o) begin
            @(posedge clk_i);
            #1;
            lat++;
        end
        first_data = rsp_data_o;
        // Random backpressure on the response channel
        coin = $random(seed);
        rsp_ready_i = coin[0];
        while (!rsp_ready_i) begin
            @(posedge clk_i);
            #1;
            coin = $random(seed);
            rsp_ready_i = coin[0];
        end
        rdata = rsp_data_o;
        rop   = rsp_op_o;
        check_equal("response valid held", 1, 32'(rsp_valid_o));
        check_equal("response data held", first_data, rdata);
        @(posedge clk_i);
        #1;
        rsp_ready_i = 1'b0;
    endtask

    task automatic bus_write(input string name, input logic [3:0] off,
                             input logic [31:0] data);
        logic [31:0] rdata;
        logic [2:0]  rop;
        int          lat;
        bus_access(OP_PUT_FULL, UART_BASE_ADDR | 32'(off), data, rdata, rop, lat);
        check_equal({name, " opcode"}, 32'(OP_ACK), 32'(rop));
        check_equal({name, " latency"}, 1, lat);
        if (off == REG_WDATA) tx_expect.push_back(data[7:0]);
    endtask

    task automatic bus_read(input string name, input logic [3:0] off,
                            output logic [31:0] data, output int lat);
        logic [2:0] rop;
        bus_access(OP_GET, UART_BASE_ADDR | 32'(off), 32'h0, data, rop, lat);
        check_equal({name, " opcode"}, 32'(OP_ACK_DATA), 32'(rop));
    endtask

    task automatic compare_frames(input string name);
        while (tx_seen.size() < tx_expect.size()) begin
            @(posedge clk_i);
            #1;
        end
        while (tx_expect.size() > 0) begin
            check_equal(name, 32'(tx_expect.pop_front()), 32'(tx_seen.pop_front()));
        end
    endtask

    // ===================================================================
    // Serial monitor on tx_o
    // ===================================================================

    initial begin : serial_monitor
        logic [FRAME_CYCLES-1:0] samples;
        logic [7:0]              data;
        int                      frame;
        frame = 0;
        @(posedge rstn_i);
        forever begin
            @(negedge tx_o);
            // One sample per cycle on the falling clock edge
            for (int i = 0; i < FRAME_CYCLES; i++) begin
                @(negedge clk_i);
                samples[i] = tx_o;
            end
            for (int bit_n = 0; bit_n < 10; bit_n++) begin
                assert (samples[bit_n*BAUD_DIV +: BAUD_DIV] ==
                        {BAUD_DIV{samples[bit_n*BAUD_DIV]}}) else begin
                    errors++;
                    $display("[ERROR] frame %0d: bit %0d changed level inside its period",
                             frame, bit_n);
                end
            end
            // Start bit still low at mid-bit
            check_equal("start bit", 0, 32'(samples[BAUD_DIV/2]));
            check_equal("stop bit", 1, 32'(samples[9*BAUD_DIV]));
            for (int k = 0; k < 8; k++) begin
                data[k] = samples[(k + 1) * BAUD_DIV];
            end
            tx_seen.push_back(data);
            frame++;
        end
    end

    // ===================================================================
    // Test sequence
    // ===================================================================

    initial begin
        logic [31:0] rd;
        logic [7:0]  rx_exp [3];
        logic [7:0]  b;
        int          lat;
        rstn_i      = 1'b0;
        req_valid_i = 1'b0;
        req_addr_i  = '0;
        req_data_i  = '0;
        req_op_i    = OP_GET;
        rsp_ready_i = 1'b0;
        repeat (10) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        // Reset state
        check_equal("reset tx_o", 1, 32'(tx_o));
        check_equal("reset req_ready", 1, 32'(req_ready_o));
        check_equal("reset rsp_valid", 0, 32'(rsp_valid_o));
        bus_read("reset status", REG_STATUS, rd, lat);
        check_equal("reset status value", 32'hA, rd);

        // Control register write and read-back
        bus_write("ctrl write", REG_CTRL, 32'h0008_5550);
        bus_read("ctrl read", REG_CTRL, rd, lat);
        check_equal("ctrl read-back", 32'h0008_5550, rd);
        check_equal("ctrl read latency", 1, lat);

        // Single frame on tx_o
        bus_write("tx enable", REG_CTRL, CTRL_TX);
        bus_write("tx byte", REG_WDATA, 32'hA5);
        compare_frames("tx frame");

        // Loopback where the first read arrives before its byte
        bus_write("rx enable", REG_CTRL, CTRL_TXRX);
        for (int i = 0; i < 3; i++) begin
            rx_exp[i] = 8'($random(seed));
            bus_write("loopback tx", REG_WDATA, 32'(rx_exp[i]));
        end
        for (int i = 0; i < 3; i++) begin
            bus_read("loopback rx", REG_RDATA, rd, lat);
            check_equal("loopback rx data", 32'(rx_exp[i]), rd);
            if (i == 0) check_equal("rx read stalls", 1, 32'(lat > 1));
        end
        compare_frames("loopback frames");

        // Fill the transmit FIFO with both engines off
        bus_write("engines off", REG_CTRL, CTRL_OFF);
        for (int i = 0; i < FIFO_DEPTH_DEF; i++) begin
            b = 8'($random(seed));
            bus_write("fill tx", REG_WDATA, 32'(b));
        end
        bus_read("full status", REG_STATUS, rd, lat);
        check_equal("full status value", 32'h9, rd);
        // One pop frees a slot so the next two writes fill it and then stall
        bus_write("tx only", REG_CTRL, CTRL_TX);
        bus_write("refill tx", REG_WDATA, 32'h5A);
        bus_write("held tx", REG_WDATA, 32'hC3);
        repeat (BAUD_DIV) begin
            check_equal("req_ready while tx full", 0, 32'(req_ready_o));
            @(posedge clk_i);
            #1;
        end
        compare_frames("drained frames");

        // Looped-back bytes are dropped while receive is disabled
        bus_read("drop status", REG_STATUS, rd, lat);
        check_equal("drop status value", 32'hA, rd);
        repeat (FRAME_CYCLES + 10) @(posedge clk_i);
        #1;
        check_equal("extra frames", 0, tx_seen.size());

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- uart_periph.f
hdl/uart_pkg.sv
hdl/fifo_if.sv
hdl/byte_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_regs.sv
hdl/uart_top.sv
testbench/tb_uart_top.sv
